//--- rx_align.f
+incdir+include
verilog/rx_align_pkg.sv
verilog/block_aligner.sv
verilog/link_sync_monitor.sv
verilog/axil_status_regs.sv
verilog/rx_align_top.sv
testbench/rx_align_properties.sv
testbench/rx_align_tb.sv

//--- Makefile
# Verilator simulation of the receive word alignment stage.

LOG = sim.log

sim:
	verilator --binary --timing --assert --top-module rx_align_tb -Mdir obj_dir -f rx_align.f
	./obj_dir/Vrx_align_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- testbench/rx_align_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "rx_align_settings.svh"

module rx_align_tb import rx_align_pkg::*; ();

	localparam int STREAM_A		= 300;	// Words before the counter clear.
	localparam int STREAM_B		= 120;	// Words after it.
	localparam int AXI_MARGIN	= 1000;	// Cycles for bus traffic and idle gaps.
	localparam int TIMEOUT_NS	= (16 + STREAM_A + STREAM_B + AXI_MARGIN) * 20;

	logic			clk;
	logic			arst_n;
	logic [3:0]		kchar_in;
	symbol_word_u	data_in;
	logic [3:0]		kchar_out;
	symbol_word_u	data_out;
	logic			link_up;
	logic			s_axil_awvalid;
	logic			s_axil_awready;
	logic [3:0]		s_axil_awaddr;
	logic			s_axil_wvalid;
	logic			s_axil_wready;
	logic [31:0]	s_axil_wdata;
	logic [3:0]		s_axil_wstrb;
	logic			s_axil_bvalid;
	logic			s_axil_bready;
	logic [1:0]		s_axil_bresp;
	logic			s_axil_arvalid;
	logic			s_axil_arready;
	logic [3:0]		s_axil_araddr;
	logic			s_axil_rvalid;
	logic			s_axil_rready;
	logic [31:0]	s_axil_rdata;
	logic [1:0]		s_axil_rresp;

	int				mismatch_count = 0;
	int				other_count = 0;
	logic [31:0]	lfsr_state = 32'hb624;	// Fixed seed.
	logic			model_on = 1'b0;		// Model runs after reset.

	rx_align_top u_rx_align_top (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period.
	end

	// ----------------------------------------------------------------------
	// Checking and random bits

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// Galois, maximal taps.
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};	// One step per bit.
		end
	endtask

	// ----------------------------------------------------------------------
	// Reference model, stepped before each rising edge

	logic							m_lane = 1'b0;
	logic							m_lane_prev = 1'b0;
	logic [1:0]						m_khi = '0;		// Delayed upper k flags.
	logic [15:0]					m_dhi = '0;		// Delayed upper half.
	int								m_run = 0;
	logic							m_link = 1'b0;
	logic [`RX_CNT_WIDTH-1:0]		m_commas = '0;
	logic [`RX_CNT_WIDTH-1:0]		m_realigns = '0;
	logic							clr_pend = 1'b0;	// Clear lands next edge.

	always @(negedge clk) begin
		logic [3:0]		exp_k;
		logic [31:0]	exp_d;
		logic [31:0]	in_d;
		logic			out_c0;
		logic			out_c2;
		if (model_on) begin
			in_d = data_in;
			if (!m_lane) begin
				exp_k = kchar_in;	// Straight through.
				exp_d = in_d;
			end else begin
				exp_k = {kchar_in[1:0], m_khi};	// Low half moves up.
				exp_d = {in_d[15:0], m_dhi};
			end
			check("kchar_out", 32'(kchar_out), 32'(exp_k));
			check("data_out", data_out, exp_d);
			check("link_up", 32'(link_up), 32'(m_link));
			out_c0 = exp_k[0] && (exp_d[7:0] == `RX_COMMA_CHAR);
			out_c2 = exp_k[2] && (exp_d[23:16] == `RX_COMMA_CHAR);
			if (out_c2) begin
				m_run = 0;		// Loss of sync.
				m_link = 1'b0;
			end else if (out_c0) begin
				if (m_run < `RX_LOCK_COUNT)
					m_run++;
				if (m_run == `RX_LOCK_COUNT)
					m_link = 1'b1;
			end
			if (clr_pend) begin
				m_commas = '0;
				m_realigns = '0;
			end else begin
				if (out_c0)
					m_commas++;		// Wraps at the counter width.
				if (m_lane != m_lane_prev)
					m_realigns++;
			end
			clr_pend = s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready
				&& (s_axil_awaddr == `RX_REG_CONTROL) && s_axil_wdata[0] && s_axil_wstrb[0];
			m_lane_prev = m_lane;
			if (kchar_in[2] && (in_d[23:16] == `RX_COMMA_CHAR))
				m_lane = 1'b1;	// Lane 2 wins a tie.
			else if (kchar_in[0] && (in_d[7:0] == `RX_COMMA_CHAR))
				m_lane = 1'b0;
			m_khi = kchar_in[3:2];
			m_dhi = in_d[31:16];
		end
	end

	// ----------------------------------------------------------------------
	// Stream stimulus

	task automatic drive_stream(input int words);
		logic [31:0]	r;
		logic [31:0]	w;
		int				left;
		logic			lane_hi;
		left = 0;
		lane_hi = 1'b0;
		for (int n = 0; n < words; n++) begin
			if (left == 0) begin
				random_bits(1, r);
				lane_hi = r[0];			// Comma lane of this burst.
				random_bits(4, r);
				left = 6 + int'(r[3:0]);
			end
			left--;
			random_bits(4, r);
			random_bits(32, w);
			@(posedge clk);
			#2;
			if (r < 6) begin
				kchar_in = lane_hi ? 4'b0100 : 4'b0001;
				data_in = lane_hi ? {w[31:24], `RX_COMMA_CHAR, w[15:0]} : {w[31:8], `RX_COMMA_CHAR};
			end else if (r < 13) begin
				kchar_in = 4'b0000;		// Plain data.
				data_in = w;
			end else if (r < 15) begin
				kchar_in = 4'b0000;		// Idle.
				data_in = '0;
			end else begin
				kchar_in = 4'b0101;		// Commas in both halves.
				data_in = {w[31:24], `RX_COMMA_CHAR, w[15:8], `RX_COMMA_CHAR};
			end
		end
	endtask

	task automatic drive_idle(input int words);
		repeat (words) begin
			@(posedge clk);
			#2;
			kchar_in = 4'b0000;
			data_in = '0;
		end
	endtask

	// ----------------------------------------------------------------------
	// AXI4-Lite master

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		logic [31:0]	r;
		int				waited;
		@(posedge clk);
		#2;
		s_axil_awvalid = 1'b1;
		s_axil_awaddr = addr;
		s_axil_wvalid = 1'b1;
		s_axil_wdata = data;
		s_axil_wstrb = strb;
		waited = 0;
		@(negedge clk);
		while (!s_axil_awready && waited < 32) begin
			@(negedge clk);
			waited++;
		end
		if (!s_axil_awready) begin
			other_count++;
			$display("ERROR: write to address %h was never accepted", addr);
		end else begin
			check("wready", 32'(s_axil_wready), 32'd1);	// Raised with awready.
		end
		@(posedge clk);
		#2;
		s_axil_awvalid = 1'b0;
		s_axil_wvalid = 1'b0;
		random_bits(3, r);
		repeat (int'(r[2:0])) @(posedge clk);	// Slow B acceptance.
		#2;
		s_axil_bready = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!s_axil_bvalid && waited < 32) begin
			@(negedge clk);
			waited++;
		end
		if (!s_axil_bvalid) begin
			other_count++;
			$display("ERROR: no write response for address %h", addr);
		end
		resp = s_axil_bresp;
		@(posedge clk);
		#2;
		s_axil_bready = 1'b0;
		@(negedge clk);
		check("bvalid after take", 32'(s_axil_bvalid), 32'd0);	// No duplicate.
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic [31:0]	r;
		int				waited;
		@(posedge clk);
		#2;
		s_axil_arvalid = 1'b1;
		s_axil_araddr = addr;
		waited = 0;
		@(negedge clk);
		while (!s_axil_arready && waited < 32) begin
			@(negedge clk);
			waited++;
		end
		if (!s_axil_arready) begin
			other_count++;
			$display("ERROR: read of address %h was never accepted", addr);
		end
		@(posedge clk);
		#2;
		s_axil_arvalid = 1'b0;
		random_bits(3, r);
		repeat (int'(r[2:0])) @(posedge clk);	// Slow R acceptance.
		#2;
		s_axil_rready = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!s_axil_rvalid && waited < 32) begin
			@(negedge clk);
			waited++;
		end
		if (!s_axil_rvalid) begin
			other_count++;
			$display("ERROR: no read data for address %h", addr);
		end
		data = s_axil_rdata;
		resp = s_axil_rresp;
		@(posedge clk);
		#2;
		s_axil_rready = 1'b0;
		@(negedge clk);
		check("rvalid after take", 32'(s_axil_rvalid), 32'd0);
	endtask

	task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
			input logic [1:0] exp_resp, input string name);
		logic [31:0]	data;
		logic [1:0]		resp;
		axi_read(addr, data, resp);
		check({name, " rdata"}, data, exp_data);
		check({name, " rresp"}, 32'(resp), 32'(exp_resp));
	endtask

	task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic [1:0] exp_resp, input string name);
		logic [1:0]	resp;
		axi_write(addr, data, strb, resp);
		check({name, " bresp"}, 32'(resp), 32'(exp_resp));
	endtask

	// ----------------------------------------------------------------------
	// Test sequence

	initial begin
		arst_n = 1'b0;
		kchar_in = 4'b0000;
		data_in = '0;
		s_axil_awvalid = 1'b0;
		s_axil_awaddr = '0;
		s_axil_wvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_bready = 1'b0;
		s_axil_arvalid = 1'b0;
		s_axil_araddr = '0;
		s_axil_rready = 1'b0;
		repeat (16) @(posedge clk);
		check("link_up in reset", 32'(link_up), 32'd0);
		check("bvalid in reset", 32'(s_axil_bvalid), 32'd0);
		check("rvalid in reset", 32'(s_axil_rvalid), 32'd0);
		#2;
		arst_n = 1'b1;
		model_on = 1'b1;
		drive_stream(STREAM_A);		// Lock, loss and relock.
		drive_idle(8);
		read_expect(`RX_REG_STATUS, {30'b0, m_lane, m_link}, OKAY, "STATUS");
		read_expect(`RX_REG_COMMAS, 32'(m_commas), OKAY, "COMMAS");
		read_expect(`RX_REG_REALIGNS, 32'(m_realigns), OKAY, "REALIGNS");
		read_expect(`RX_REG_CONTROL, 32'd0, OKAY, "CONTROL");
		read_expect(4'h2, 32'd0, SLVERR, "unmapped 0x2");
		read_expect(4'h7, 32'd0, SLVERR, "unmapped 0x7");
		write_expect(4'h6, 32'd1, 4'hf, SLVERR, "unmapped 0x6");
		write_expect(`RX_REG_STATUS, 32'd1, 4'hf, OKAY, "STATUS");
		write_expect(`RX_REG_CONTROL, 32'd1, 4'he, OKAY, "CONTROL no strobe");
		read_expect(`RX_REG_COMMAS, 32'(m_commas), OKAY, "COMMAS kept");
		write_expect(`RX_REG_CONTROL, 32'd1, 4'h1, OKAY, "CONTROL clear");
		read_expect(`RX_REG_COMMAS, 32'd0, OKAY, "COMMAS cleared");
		read_expect(`RX_REG_REALIGNS, 32'd0, OKAY, "REALIGNS cleared");
		drive_stream(STREAM_B);		// Counting from zero again.
		drive_idle(8);
		read_expect(`RX_REG_COMMAS, 32'(m_commas), OKAY, "COMMAS resumed");
		read_expect(`RX_REG_REALIGNS, 32'(m_realigns), OKAY, "REALIGNS resumed");
		read_expect(`RX_REG_STATUS, {30'b0, m_lane, m_link}, OKAY, "STATUS end");
		$display("Errors: %0d mismatches, %0d bus failures, %0d assertion failures",
			mismatch_count, other_count, u_rx_align_top.u_rx_align_properties.assert_fail_count);
		if (mismatch_count == 0 && other_count == 0
				&& u_rx_align_top.u_rx_align_properties.assert_fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog, sized from the stream lengths plus bus traffic.
	initial begin
		#(TIMEOUT_NS);
		$display("ERROR: run did not finish within %0d ns", TIMEOUT_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/rx_align_properties.sv
`default_nettype none
`timescale 1ns/100ps

module rx_align_properties (
	input wire			clk,
	input wire			arst_n,
	input wire			bvalid,
	input wire			bready,
	input wire			rvalid,
	input wire			rready,
	input wire [31:0]	rdata,
	input wire			clear_counts,
	input wire			comma_lane,
	input wire [3:0]	kchar_in,
	input wire [31:0]	data_in,
	input wire [3:0]	kchar_out,
	input wire [31:0]	data_out
);

	int	assert_fail_count = 0;	// Read by the testbench at the end.

	// ----------------------------------------------------------------------
	// AXI4-Lite response channels

	bvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
		else begin
			assert_fail_count++;
			$error("bvalid dropped before bready");
		end

	rvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			assert_fail_count++;
			$error("rvalid or rdata changed before rready");
		end

	clear_single: assert property (@(posedge clk) disable iff (!arst_n)
		clear_counts |=> !clear_counts)
		else begin
			assert_fail_count++;
			$error("clear_counts longer than one cycle");
		end

	// ----------------------------------------------------------------------
	// Aligner pass-through in lane 0

	lane0_passthru: assert property (@(posedge clk) disable iff (!arst_n)
		!comma_lane |-> (data_out == data_in) && (kchar_out == kchar_in))
		else begin
			assert_fail_count++;
			$error("aligner output differs from input in lane 0");
		end

endmodule

// Hooked onto the DUT top, where both blocks meet.
bind rx_align_top rx_align_properties u_rx_align_properties (
	.clk			(clk),
	.arst_n			(arst_n),
	.bvalid			(s_axil_bvalid),
	.bready			(s_axil_bready),
	.rvalid			(s_axil_rvalid),
	.rready			(s_axil_rready),
	.rdata			(s_axil_rdata),
	.clear_counts	(clear_counts),
	.comma_lane		(comma_lane),
	.kchar_in		(kchar_in),
	.data_in		(data_in),
	.kchar_out		(kchar_out),
	.data_out		(data_out)
);

`default_nettype wire

//--- verilog/rx_align_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "rx_align_settings.svh"

module rx_align_top import rx_align_pkg::*; (
	input wire			clk,
	input wire			arst_n,

	input wire [3:0]	kchar_in,
	input symbol_word_u	data_in,
	output logic [3:0]	kchar_out,
	output symbol_word_u	data_out,
	output logic		link_up,

	input wire			s_axil_awvalid,
	output logic		s_axil_awready,
	input wire [`RX_AXI_ADDR_WIDTH-1:0]	s_axil_awaddr,
	input wire			s_axil_wvalid,
	output logic		s_axil_wready,
	input wire [31:0]	s_axil_wdata,
	input wire [3:0]	s_axil_wstrb,
	output logic		s_axil_bvalid,
	input wire			s_axil_bready,
	output logic [1:0]	s_axil_bresp,
	input wire			s_axil_arvalid,
	output logic		s_axil_arready,
	input wire [`RX_AXI_ADDR_WIDTH-1:0]	s_axil_araddr,
	output logic		s_axil_rvalid,
	input wire			s_axil_rready,
	output logic [31:0]	s_axil_rdata,
	output logic [1:0]	s_axil_rresp
);

	// ----------------------------------------------------------------------
	// Internal links

	logic	comma_lane;		// Aligner lane choice.
	logic	clear_counts;	// Software counter clear.
	logic [`RX_CNT_WIDTH-1:0]	comma_count;
	logic [`RX_CNT_WIDTH-1:0]	realign_count;

	block_aligner u_block_aligner (
		.clk		(clk),
		.arst_n		(arst_n),
		.kchar_in	(kchar_in),
		.data_in	(data_in),
		.kchar_out	(kchar_out),
		.data_out	(data_out),
		.comma_lane	(comma_lane)
	);

	// Watches the aligned stream, not the raw one.
	link_sync_monitor u_link_sync_monitor (
		.clk			(clk),
		.arst_n			(arst_n),
		.kchar			(kchar_out),
		.data			(data_out),
		.comma_lane		(comma_lane),
		.clear_counts	(clear_counts),
		.link_up		(link_up),
		.comma_count	(comma_count),
		.realign_count	(realign_count)
	);

	axil_status_regs u_axil_status_regs (
		.clk			(clk),
		.arst_n			(arst_n),
		.awvalid		(s_axil_awvalid),
		.awready		(s_axil_awready),
		.awaddr			(s_axil_awaddr),
		.wvalid			(s_axil_wvalid),
		.wready			(s_axil_wready),
		.wdata			(s_axil_wdata),
		.wstrb			(s_axil_wstrb),
		.bvalid			(s_axil_bvalid),
		.bready			(s_axil_bready),
		.bresp			(s_axil_bresp),
		.arvalid		(s_axil_arvalid),
		.arready		(s_axil_arready),
		.araddr			(s_axil_araddr),
		.rvalid			(s_axil_rvalid),
		.rready			(s_axil_rready),
		.rdata			(s_axil_rdata),
		.rresp			(s_axil_rresp),
		.link_up		(link_up),
		.comma_lane		(comma_lane),
		.comma_count	(comma_count),
		.realign_count	(realign_count),
		.clear_counts	(clear_counts)
	);

endmodule

`default_nettype wire

//--- verilog/axil_status_regs.sv
`default_nettype none
`timescale 1ns/100ps
`include "rx_align_settings.svh"

module axil_status_regs import rx_align_pkg::*; (
	input wire			clk,
	input wire			arst_n,

	input wire			awvalid,
	output logic		awready,
	input wire [`RX_AXI_ADDR_WIDTH-1:0]	awaddr,
	input wire			wvalid,
	output logic		wready,
	input wire [31:0]	wdata,
	input wire [3:0]	wstrb,
	output logic		bvalid,
	input wire			bready,
	output logic [1:0]	bresp,

	input wire			arvalid,
	output logic		arready,
	input wire [`RX_AXI_ADDR_WIDTH-1:0]	araddr,
	output logic		rvalid,
	input wire			rready,
	output logic [31:0]	rdata,
	output logic [1:0]	rresp,

	input wire			link_up,
	input wire			comma_lane,
	input wire [`RX_CNT_WIDTH-1:0]	comma_count,
	input wire [`RX_CNT_WIDTH-1:0]	realign_count,
	output logic		clear_counts
);

	// ----------------------------------------------------------------------
	// Write channel

	logic	wr_fire;	// AW and W accepted this cycle.
	logic	wr_mapped;	// Address hits a register.

	assign wr_fire = awvalid && awready && wvalid && wready;

	always_comb begin
		case (awaddr)
			`RX_REG_STATUS, `RX_REG_COMMAS,
			`RX_REG_REALIGNS, `RX_REG_CONTROL:	wr_mapped = 1'b1;
			default:							wr_mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready			<= 1'b0;
			wready			<= 1'b0;
			bvalid			<= 1'b0;
			bresp			<= OKAY;
			clear_counts	<= 1'b0;
		end else begin
			awready			<= 1'b0;	// Ready is a one-cycle pulse.
			wready			<= 1'b0;
			clear_counts	<= 1'b0;
			if (awvalid && wvalid && !bvalid && !awready) begin
				awready	<= 1'b1;
				wready	<= 1'b1;
			end
			if (wr_fire) begin
				bvalid	<= 1'b1;
				bresp	<= wr_mapped ? OKAY : SLVERR;
				clear_counts	<= (awaddr == `RX_REG_CONTROL) && wdata[0] && wstrb[0];
			end else if (bready)
				bvalid	<= 1'b0;	// Held until taken.
		end
	end

	// ----------------------------------------------------------------------
	// Read channel

	logic [31:0]	rd_mux;	// Register selected by araddr.
	logic			rd_err;	// Unmapped read.

	always_comb begin
		rd_mux	= '0;
		rd_err	= 1'b0;
		case (araddr)
			`RX_REG_STATUS:		rd_mux = {30'b0, comma_lane, link_up};
			`RX_REG_COMMAS:		rd_mux = {{(32-`RX_CNT_WIDTH){1'b0}}, comma_count};
			`RX_REG_REALIGNS:	rd_mux = {{(32-`RX_CNT_WIDTH){1'b0}}, realign_count};
			`RX_REG_CONTROL:	rd_mux = '0;	// Write-only bits.
			default:			rd_err = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready	<= 1'b0;
			rvalid	<= 1'b0;
			rresp	<= OKAY;
		end else begin
			arready	<= arvalid && !rvalid && !arready;
			if (arvalid && arready) begin
				rvalid	<= 1'b1;
				rresp	<= rd_err ? SLVERR : OKAY;
			end else if (rready)
				rvalid	<= 1'b0;
		end
	end

	// Payload, captured at the AR handshake.
	always_ff @(posedge clk) begin
		if (arvalid && arready)
			rdata	<= rd_mux;
	end

endmodule

`default_nettype wire

//--- verilog/link_sync_monitor.sv
`default_nettype none
`timescale 1ns/100ps
`include "rx_align_settings.svh"

module link_sync_monitor import rx_align_pkg::*; (
	input wire			clk,
	input wire			arst_n,

	input wire [3:0]	kchar,
	input symbol_word_u	data,
	input wire			comma_lane,
	input wire			clear_counts,

	output logic		link_up,
	output logic [`RX_CNT_WIDTH-1:0]	comma_count,
	output logic [`RX_CNT_WIDTH-1:0]	realign_count
);

	// ----------------------------------------------------------------------
	// Comma position in the aligned word

	logic	comma_lane0;	// Comma where it belongs.
	logic	comma_lane2;	// Comma half a word off, sync lost.

	assign comma_lane0 = kchar[0] && (data.bytes[0] == `RX_COMMA_CHAR);
	assign comma_lane2 = kchar[2] && (data.bytes[2] == `RX_COMMA_CHAR);

	// ----------------------------------------------------------------------
	// Lock tracking

	logic [$clog2(`RX_LOCK_COUNT+1)-1:0]	run_cnt;	// Saturating lane-0 run.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run_cnt	<= '0;
			link_up	<= 1'b0;
		end else if (comma_lane2) begin
			run_cnt	<= '0;		// Misplaced comma drops lock.
			link_up	<= 1'b0;
		end else if (comma_lane0) begin
			if (int'(run_cnt) < `RX_LOCK_COUNT)
				run_cnt	<= run_cnt + 1'b1;
			if (int'(run_cnt) >= `RX_LOCK_COUNT - 1)
				link_up	<= 1'b1;	// Run reaches the lock count here.
		end
	end

	// ----------------------------------------------------------------------
	// Event counters

	logic	lane_prev;	// Lane choice one clock ago.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			lane_prev	<= 1'b0;
		else
			lane_prev	<= comma_lane;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			comma_count		<= '0;
			realign_count	<= '0;
		end else if (clear_counts) begin
			comma_count		<= '0;	// Clear beats a same-cycle event.
			realign_count	<= '0;
		end else begin
			if (comma_lane0)
				comma_count		<= comma_count + 1'b1;	// Wraps.
			if (comma_lane != lane_prev)
				realign_count	<= realign_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/block_aligner.sv
`default_nettype none
`timescale 1ns/100ps
`include "rx_align_settings.svh"

module block_aligner import rx_align_pkg::*; (
	input wire			clk,
	input wire			arst_n,

	input wire [3:0]	kchar_in,
	input symbol_word_u	data_in,

	output logic [3:0]	kchar_out,
	output symbol_word_u	data_out,
	output logic		comma_lane
);

	// ----------------------------------------------------------------------
	// Half-word delay

	logic [1:0]		kchar_hi_ff;	// Upper k flags of last word.
	logic [15:0]	data_hi_ff;		// Upper half of last word.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			kchar_hi_ff	<= '0;
			data_hi_ff	<= '0;
		end else begin
			kchar_hi_ff	<= kchar_in[3:2];	// Only the upper half is spliced.
			data_hi_ff	<= data_in.halves[1];
		end
	end

	// ----------------------------------------------------------------------
	// Comma lane detection

	logic	comma_lo;	// K28.5 at byte 0.
	logic	comma_hi;	// K28.5 at byte 2.

	assign comma_lo = kchar_in[0] && (data_in.halves[0][7:0] == `RX_COMMA_CHAR);
	assign comma_hi = kchar_in[2] && (data_in.halves[1][7:0] == `RX_COMMA_CHAR);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			comma_lane	<= 1'b0;
		else if (comma_hi)
			comma_lane	<= 1'b1;	// Upper half wins a tie.
		else if (comma_lo)
			comma_lane	<= 1'b0;
	end

	// ----------------------------------------------------------------------
	// Output mux

	always_comb begin
		if (!comma_lane) begin
			kchar_out	= kchar_in;		// Already in lane 0.
			data_out	= data_in;
		end else begin
			kchar_out			= {kchar_in[1:0], kchar_hi_ff};	// Half-word shift.
			data_out.halves[1]	= data_in.halves[0];
			data_out.halves[0]	= data_hi_ff;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rx_align_pkg.sv
`default_nettype none

package rx_align_pkg;

	// ----------------------------------------------------------------------
	// One 32-bit symbol word from the transceiver

	// The aligner splices 16-bit halves while the monitor looks at
	// single byte lanes, so the same word is decoded both ways.
	typedef union packed {
		logic [1:0][15:0]	halves;	// Transceiver internal width.
		logic [3:0][7:0]	bytes;	// Byte lanes 0 to 3.
	} symbol_word_u;

	// ----------------------------------------------------------------------
	// AXI4-Lite response codes

	typedef enum logic [1:0] {
		OKAY	= 2'b00,	// Normal access.
		SLVERR	= 2'b10		// Unmapped address.
	} axi_resp_e;

endpackage

`default_nettype wire

//--- include/rx_align_settings.svh
`ifndef RX_ALIGN_SETTINGS_SVH
`define RX_ALIGN_SETTINGS_SVH

// ----------------------------------------------------------------------
// Link framing

`define RX_COMMA_CHAR		8'hbc	// K28.5.
`define RX_LOCK_COUNT		4		// Lane-0 commas in a row before link up.
`define RX_CNT_WIDTH		16		// Event counters, wrapping.

// ----------------------------------------------------------------------
// Status register map, byte addresses

`define RX_AXI_ADDR_WIDTH	4
`define RX_REG_STATUS		4'h0	// Bit 0 link up, bit 1 comma lane.
`define RX_REG_COMMAS		4'h4	// Lane-0 comma count.
`define RX_REG_REALIGNS		4'h8	// Lane change count.
`define RX_REG_CONTROL		4'hc	// Bit 0 clears both counters.

// Write a 1 to CONTROL bit 0 for a clear; reads back as 0.

`endif
